// File: tests/mem_system_input.txt
// columns: op addr wdata exp_rdata exp_hit exp_cycles, all hex
// op 0 read, 1 write, 2 end of list; exp_cycles counts from request to done
0000 0828 0000 0000 0000 0009
0001 1082 beef 0000 0000 0009
0000 1082 0000 beef 0001 0001
0001 182c 1234 0000 0000 0009
0000 0828 0000 0000 0001 0001
0000 182c 0000 1234 0001 0001
0001 082a a5a5 0000 0001 0001
0000 2028 0000 0000 0000 0011
0000 0828 0000 0000 0001 0001
0000 182c 0000 1234 0000 0011
0000 082a 0000 a5a5 0000 0009
0000 2028 0000 0000 0000 0009
0000 182c 0000 1234 0000 0009
0000 2028 0000 0000 0001 0001
0001 2028 5a5a 0000 0001 0001
0000 2028 0000 5a5a 0001 0001
0000 082a 0000 a5a5 0000 0011
0000 2028 0000 5a5a 0000 0009
0000 1082 0000 beef 0001 0001
0001 1084 0f0f 0000 0001 0001
0000 1084 0000 0f0f 0001 0001
0000 1080 0000 0000 0001 0001
0002 0000 0000 0000 0000 0000

// File: build.f
design/cache_pkg.sv
design/cache_way.sv
design/way_select.sv
design/cache_ctrl.sv
design/bank_mem.sv
design/mem_system.sv
tests/tb_mem_system.sv

// File: Makefile
# Verilator flow for the cache memory system

VERILATOR ?= verilator
TOP       ?= tb_mem_system
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: tests/tb_mem_system.sv
/* cache memory system testbench */
`timescale 1ns/10ps
`default_nettype none

module tb_mem_system;

   localparam int FIELDS          = 6;   // values per request line
   localparam int MAX_LINES       = 64;
   localparam int RESET_CYCLES    = 4;
   localparam int DONE_LIMIT      = 17;  // longest request, a dirty miss
   localparam int CYCLES_PER_LINE = 20;

   localparam logic [15:0] OP_READ  = 16'h0000;
   localparam logic [15:0] OP_WRITE = 16'h0001;
   localparam logic [15:0] OP_END   = 16'h0002;

   logic        clk;
   logic        rst_n;
   logic [15:0] addr;
   logic [15:0] data_in;
   logic        rd;
   logic        wr;
   logic [15:0] data_out;
   logic        done;
   logic        stall;
   logic        cache_hit;

   logic [15:0] stim [MAX_LINES*FIELDS];
   int          num_lines      = 0;
   int          check_count    = 0;
   int          mismatch_count = 0;
   int          fail_count     = 0;
   int          cycle_count    = 0;
   int          timeout_limit  = 0;
   int          cur_req        = 0;
   logic        limit_set      = 1'b0;

   mem_system mem_system_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .addr      (addr),
      .data_in   (data_in),
      .rd        (rd),
      .wr        (wr),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit)
   );

   always #20 clk = ~clk;  // 40 ns period

   // stop a run that never reaches the end of the list
   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (limit_set && cycle_count >= timeout_limit) begin
         $display("run stopped after %0d cycles before all requests completed", cycle_count);
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   task automatic check_value(input string name, input logic [15:0] actual,
                              input logic [15:0] expected);
      check_count++;
      if (actual !== expected) begin
         mismatch_count++;
         $display("ERROR %s: got 0x%h, expected 0x%h (request %0d)",
                  name, actual, expected, cur_req);
      end
   endtask

   task automatic load_stimulus();
      $readmemh("tests/mem_system_input.txt", stim);
      num_lines = 0;
      while (num_lines < MAX_LINES && stim[num_lines*FIELDS] !== OP_END) begin
         num_lines++;
      end
      if (num_lines == MAX_LINES) begin
         fail_count++;
         $display("input file has no end marker within %0d requests", MAX_LINES);
      end
      if (num_lines == 0) begin
         fail_count++;
         $display("input file holds no requests");
      end
   endtask

   // one request, from strobe to done
   task automatic run_request(input int idx);
      logic [15:0] op;
      logic [15:0] exp_rdata;
      logic [15:0] exp_hit;
      logic [15:0] exp_cycles;
      logic        seen_done;
      int          cycles;
      op         = stim[idx*FIELDS+0];
      exp_rdata  = stim[idx*FIELDS+3];
      exp_hit    = stim[idx*FIELDS+4];
      exp_cycles = stim[idx*FIELDS+5];
      cur_req    = idx + 1;
      while (stall) begin
         @(negedge clk);
      end
      check_value("done", 16'(done), 16'h0000);
      addr    = stim[idx*FIELDS+1];
      data_in = stim[idx*FIELDS+2];
      rd      = (op == OP_READ);
      wr      = (op == OP_WRITE);
      cycles    = 0;
      seen_done = 1'b0;
      while (!seen_done && cycles < DONE_LIMIT) begin
         @(negedge clk);
         rd = 1'b0;  // single-cycle strobe
         wr = 1'b0;
         cycles++;
         check_value("stall", 16'(stall), 16'h0001);
         seen_done = done;
      end
      if (!seen_done) begin
         fail_count++;
         $display("request %0d got no done within %0d cycles", cur_req, DONE_LIMIT);
      end else begin
         check_value("latency", 16'(cycles), exp_cycles);
         check_value("cache_hit", 16'(cache_hit), exp_hit);
         if (op == OP_READ) begin
            check_value("data_out", data_out, exp_rdata);
         end
      end
   endtask

   initial begin
      clk     = 1'b0;
      rst_n   = 1'b0;
      addr    = '0;
      data_in = '0;
      rd      = 1'b0;
      wr      = 1'b0;
      load_stimulus();
      timeout_limit = CYCLES_PER_LINE * num_lines + RESET_CYCLES;
      limit_set     = 1'b1;
      repeat (RESET_CYCLES) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      check_value("stall", 16'(stall), 16'h0000);  // idle after reset
      check_value("done", 16'(done), 16'h0000);
      check_value("cache_hit", 16'(cache_hit), 16'h0000);
      for (int i = 0; i < num_lines; i++) begin
         run_request(i);
      end
      @(negedge clk);
      $display("checks %0d, value mismatches %0d, other failures %0d",
               check_count, mismatch_count, fail_count);
      if (mismatch_count == 0 && fail_count == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: design/mem_system.sv
/* two-way cache memory system */
`timescale 1ns/10ps
`default_nettype none

module mem_system (
   input  wire logic                          clk,
   input  wire logic                          rst_n,
   input  wire logic [cache_pkg::ADDR_W-1:0]  addr,
   input  wire logic [cache_pkg::DATA_W-1:0]  data_in,
   input  wire logic                          rd,
   input  wire logic                          wr,
   output      logic [cache_pkg::DATA_W-1:0]  data_out,
   output      logic                          done,
   output      logic                          stall,
   output      logic                          cache_hit
);

   cache_pkg::way_cmd_t    cmd;
   cache_pkg::way_cmd_t    way_cmd0;
   cache_pkg::way_cmd_t    way_cmd1;
   cache_pkg::way_status_t status0;
   cache_pkg::way_status_t status1;
   cache_pkg::way_status_t merged;
   cache_pkg::mem_req_t    mem_req;
   logic [cache_pkg::DATA_W-1:0] mem_rdata;
   logic                   any_hit;
   logic                   capture;
   logic                   advance_victim;

   cache_ctrl ctrl (
      .clk            (clk),
      .rst_n          (rst_n),
      .rd             (rd),
      .wr             (wr),
      .addr           (cache_pkg::addr_t'(addr)),
      .data_in        (data_in),
      .data_out       (data_out),
      .done           (done),
      .stall          (stall),
      .cache_hit      (cache_hit),
      .cmd            (cmd),
      .capture        (capture),
      .advance_victim (advance_victim),
      .merged         (merged),
      .any_hit        (any_hit),
      .mem_req        (mem_req),
      .mem_rdata      (mem_rdata)
   );

   way_select sel (
      .clk            (clk),
      .rst_n          (rst_n),
      .cmd            (cmd),
      .capture        (capture),
      .advance_victim (advance_victim),
      .status0        (status0),
      .status1        (status1),
      .way_cmd0       (way_cmd0),
      .way_cmd1       (way_cmd1),
      .merged         (merged),
      .any_hit        (any_hit)
   );

   cache_way way0 (.clk(clk), .rst_n(rst_n), .cmd(way_cmd0), .status(status0));
   cache_way way1 (.clk(clk), .rst_n(rst_n), .cmd(way_cmd1), .status(status1));

   bank_mem mem (
      .clk   (clk),
      .rst_n (rst_n),
      .req   (mem_req),
      .rdata (mem_rdata)
   );

endmodule

`default_nettype wire

// File: design/bank_mem.sv
/* backing memory */
`timescale 1ns/10ps
`default_nettype none

module bank_mem (
   input  wire logic                          clk,
   input  wire logic                          rst_n,
   input  wire cache_pkg::mem_req_t           req,
   output      logic [cache_pkg::DATA_W-1:0]  rdata
);

   logic [cache_pkg::DATA_W-1:0] mem [2**(cache_pkg::ADDR_W-1)];
   logic [cache_pkg::DATA_W-1:0] pipe_q [cache_pkg::READ_LATENCY];
   logic [cache_pkg::ADDR_W-2:0] word_addr;

   assign word_addr = req.addr[cache_pkg::ADDR_W-1:1];  // drop byte bit
   assign rdata     = pipe_q[cache_pkg::READ_LATENCY-1];

   initial begin
      for (int i = 0; i < 2**(cache_pkg::ADDR_W-1); i++) begin
         mem[i] = '0;
      end
   end

   always_ff @(posedge clk) begin
      if (req.op == cache_pkg::MEM_WRITE) begin
         mem[word_addr] <= req.wdata;
      end
   end

   // read data pipeline
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < cache_pkg::READ_LATENCY; i++) begin
            pipe_q[i] <= '0;
         end
      end else begin
         pipe_q[0] <= (req.op == cache_pkg::MEM_READ) ? mem[word_addr] : '0;
         for (int i = 1; i < cache_pkg::READ_LATENCY; i++) begin
            pipe_q[i] <= pipe_q[i-1];
         end
      end
   end

   a_even_addr : assert property (
      @(posedge clk) disable iff (!rst_n)
      (req.op != cache_pkg::MEM_NONE) |-> !req.addr[0]
   ) else $error("odd memory address");

endmodule

`default_nettype wire

// File: design/cache_ctrl.sv
/* cache miss controller */
`timescale 1ns/10ps
`default_nettype none

module cache_ctrl (
   input  wire logic                    clk,
   input  wire logic                    rst_n,
   input  wire logic                    rd,
   input  wire logic                    wr,
   input  wire cache_pkg::addr_t        addr,
   input  wire logic [cache_pkg::DATA_W-1:0] data_in,
   output      logic [cache_pkg::DATA_W-1:0] data_out,
   output      logic                    done,
   output      logic                    stall,
   output      logic                    cache_hit,
   output      cache_pkg::way_cmd_t     cmd,
   output      logic                    capture,
   output      logic                    advance_victim,
   input  wire cache_pkg::way_status_t  merged,
   input  wire logic                    any_hit,
   output      cache_pkg::mem_req_t     mem_req,
   input  wire logic [cache_pkg::DATA_W-1:0] mem_rdata
);

   cache_pkg::ctrl_state_t state_q;
   cache_pkg::ctrl_state_t state_next;

   cache_pkg::addr_t                req_q;       // latched request
   logic [cache_pkg::DATA_W-1:0]    wdata_q;
   logic                            is_wr_q;
   logic [cache_pkg::TAG_W-1:0]     victim_tag_q;
   logic [2:0]                      cnt_q;       // evict and load word counter
   logic [1:0]                      wait_q;
   cache_pkg::word_sel_t            fill_word;

   assign fill_word = cache_pkg::word_sel_t'(cnt_q - 3'(cache_pkg::READ_LATENCY));
   assign data_out  = merged.rdata;

   always_comb begin
      state_next     = state_q;
      done           = 1'b0;
      cache_hit      = 1'b0;
      stall          = (state_q != cache_pkg::IDLE);
      capture        = 1'b0;
      advance_victim = 1'b0;

      cmd          = '0;
      cmd.tag      = req_q.tag;
      cmd.index    = req_q.index;
      cmd.word     = req_q.word;
      cmd.wdata    = wdata_q;

      mem_req.op    = cache_pkg::MEM_NONE;
      mem_req.addr  = {req_q.tag, req_q.index, cnt_q[1:0], 1'b0};
      mem_req.wdata = merged.rdata;

      case (state_q)
         cache_pkg::IDLE: begin
            if (rd || wr) begin
               state_next = cache_pkg::COMPARE;
            end
         end
         cache_pkg::COMPARE: begin
            cmd.enable = 1'b1;
            cmd.comp   = 1'b1;
            cmd.write  = is_wr_q & any_hit;
            if (any_hit) begin
               done       = 1'b1;
               cache_hit  = 1'b1;
               state_next = cache_pkg::IDLE;
            end else begin
               capture    = 1'b1;  // pick the way to refill
               state_next = cache_pkg::CHECK;
            end
         end
         cache_pkg::CHECK: begin
            cmd.enable = 1'b1;
            cmd.comp   = 1'b1;
            if (merged.valid && merged.dirty) begin
               state_next = cache_pkg::EVICT;
            end else begin
               state_next = cache_pkg::LOAD;
            end
         end
         cache_pkg::EVICT: begin
            cmd.enable   = 1'b1;
            cmd.tag      = victim_tag_q;
            cmd.word     = cnt_q[1:0];
            mem_req.op   = cache_pkg::MEM_WRITE;
            mem_req.addr = {victim_tag_q, req_q.index, cnt_q[1:0], 1'b0};  // victim's own address
            if (cnt_q == 3'(cache_pkg::WORDS_PER_LINE - 1)) begin
               state_next = cache_pkg::EVICT_WAIT;
            end
         end
         cache_pkg::EVICT_WAIT: begin
            if (wait_q == 2'(cache_pkg::WAIT_CYCLES - 1)) begin
               state_next = cache_pkg::LOAD;
            end
         end
         cache_pkg::LOAD: begin
            if (cnt_q < 3'(cache_pkg::WORDS_PER_LINE)) begin
               mem_req.op = cache_pkg::MEM_READ;
            end
            if (cnt_q >= 3'(cache_pkg::READ_LATENCY)) begin
               cmd.enable   = 1'b1;      // returned word goes into the way
               cmd.write    = 1'b1;
               cmd.valid_in = 1'b1;      // fill makes the line valid
               cmd.word     = fill_word;
               cmd.wdata    = mem_rdata;
            end
            if (cnt_q == 3'(cache_pkg::WORDS_PER_LINE + cache_pkg::READ_LATENCY - 1)) begin
               state_next = cache_pkg::FINISH;
            end
         end
         cache_pkg::FINISH: begin
            cmd.enable     = 1'b1;
            cmd.comp       = 1'b1;
            cmd.write      = is_wr_q;
            done           = 1'b1;
            advance_victim = 1'b1;
            state_next     = cache_pkg::IDLE;
         end
         default: begin
            state_next = cache_pkg::IDLE;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q <= cache_pkg::IDLE;
         is_wr_q <= 1'b0;
         cnt_q   <= '0;
         wait_q  <= '0;
      end else begin
         state_q <= state_next;
         if (state_q == cache_pkg::IDLE && (rd || wr)) begin
            is_wr_q <= wr;
         end
         if ((state_q == cache_pkg::EVICT || state_q == cache_pkg::LOAD) &&
             state_next == state_q) begin
            cnt_q <= cnt_q + 3'd1;
         end else begin
            cnt_q <= '0;
         end
         if (state_q == cache_pkg::EVICT_WAIT && state_next == state_q) begin
            wait_q <= wait_q + 2'd1;
         end else begin
            wait_q <= '0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (state_q == cache_pkg::IDLE && (rd || wr)) begin
         req_q   <= addr;
         wdata_q <= data_in;
      end
      if (state_q == cache_pkg::CHECK) begin
         victim_tag_q <= merged.tag;  // selected way's tag
      end
   end

   a_rd_wr_excl : assert property (
      @(posedge clk) disable iff (!rst_n)
      !(rd && wr)
   ) else $error("rd and wr high together");

   a_aligned_req : assert property (
      @(posedge clk) disable iff (!rst_n)
      (state_q == cache_pkg::IDLE && (rd || wr)) |-> !addr.byte_sel
   ) else $error("unaligned request accepted");

endmodule

`default_nettype wire

// File: design/way_select.sv
/* way routing and victim choice */
`timescale 1ns/10ps
`default_nettype none

module way_select (
   input  wire logic                   clk,
   input  wire logic                   rst_n,
   input  wire cache_pkg::way_cmd_t    cmd,
   input  wire logic                   capture,
   input  wire logic                   advance_victim,
   input  wire cache_pkg::way_status_t status0,
   input  wire cache_pkg::way_status_t status1,
   output      cache_pkg::way_cmd_t    way_cmd0,
   output      cache_pkg::way_cmd_t    way_cmd1,
   output      cache_pkg::way_status_t merged,
   output      logic                   any_hit
);

   logic sel_q;     // way chosen for the current miss
   logic victim_q;  // round-robin victim
   logic sel_next;

   assign any_hit = status0.hit | status1.hit;

   // invalid way first, then the round-robin bit
   always_comb begin
      if (!status0.valid) begin
         sel_next = 1'b0;
      end else if (!status1.valid) begin
         sel_next = 1'b1;
      end else begin
         sel_next = victim_q;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         sel_q    <= 1'b0;
         victim_q <= 1'b0;
      end else begin
         if (capture) begin
            sel_q <= sel_next;
         end
         if (advance_victim) begin
            victim_q <= ~victim_q;
         end
      end
   end

   always_comb begin
      way_cmd0        = cmd;
      way_cmd1        = cmd;
      way_cmd0.enable = cmd.enable & (status0.hit | (~any_hit & ~sel_q));
      way_cmd1.enable = cmd.enable & (status1.hit | (~any_hit & sel_q));
   end

   always_comb begin
      if (status0.hit) begin
         merged = status0;
      end else if (status1.hit) begin
         merged = status1;
      end else if (sel_q) begin
         merged = status1;
      end else begin
         merged = status0;
      end
   end

   // a tag lives in at most one way of a set
   a_single_hit : assert property (
      @(posedge clk) disable iff (!rst_n)
      !(status0.hit && status1.hit)
   ) else $error("both ways hit");

endmodule

`default_nettype wire

// File: design/cache_way.sv
/* one cache way */
`timescale 1ns/10ps
`default_nettype none

module cache_way (
   input  wire logic                   clk,
   input  wire logic                   rst_n,
   input  wire cache_pkg::way_cmd_t    cmd,
   output      cache_pkg::way_status_t status
);

   logic [cache_pkg::TAG_W-1:0]  tag_mem  [cache_pkg::NUM_SETS];
   logic [cache_pkg::DATA_W-1:0] data_mem [cache_pkg::NUM_SETS][cache_pkg::WORDS_PER_LINE];
   logic [cache_pkg::NUM_SETS-1:0] valid_q;
   logic [cache_pkg::NUM_SETS-1:0] dirty_q;

   logic line_valid;
   logic tag_match;
   logic do_wr;
   logic cmp_wr;
   logic fill_wr;

   assign line_valid = valid_q[cmd.index];
   assign tag_match  = (tag_mem[cmd.index] == cmd.tag);

   assign do_wr   = cmd.enable & cmd.write;
   assign cmp_wr  = do_wr & cmd.comp & line_valid & tag_match;  // store only on hit
   assign fill_wr = do_wr & ~cmd.comp;                          // line fill from memory

   // compare path is purely combinational
   always_comb begin
      status.hit   = line_valid & tag_match;
      status.valid = line_valid;
      status.dirty = dirty_q[cmd.index];
      status.tag   = tag_mem[cmd.index];
      status.rdata = data_mem[cmd.index][cmd.word];
   end

   always_ff @(posedge clk) begin
      if (cmp_wr || fill_wr) begin
         data_mem[cmd.index][cmd.word] <= cmd.wdata;
      end
      if (fill_wr) begin
         tag_mem[cmd.index] <= cmd.tag;  // new owner of the line
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid_q <= '0;
         dirty_q <= '0;
      end else begin
         if (fill_wr) begin
            valid_q[cmd.index] <= cmd.valid_in;
            dirty_q[cmd.index] <= 1'b0;  // fresh from memory
         end else if (cmp_wr) begin
            dirty_q[cmd.index] <= 1'b1;
         end
      end
   end

   // the controller may only store into a line that a fill has made valid
   a_comp_write_valid : assert property (
      @(posedge clk) disable iff (!rst_n)
      (cmd.enable && cmd.write && cmd.comp) |-> (line_valid || cmd.valid_in)
   ) else $error("compare write on invalid line without valid_in");

endmodule

`default_nettype wire

// File: design/cache_pkg.sv
/* shared cache types and geometry */
`default_nettype none

package cache_pkg;

   localparam int ADDR_W         = 16;
   localparam int DATA_W         = 16;
   localparam int TAG_W          = 5;
   localparam int INDEX_W        = 8;
   localparam int WORDS_PER_LINE = 4;
   localparam int NUM_SETS       = 256;
   localparam int READ_LATENCY   = 2;  // memory read issue to data
   localparam int WAIT_CYCLES    = 4;  // idle gap between eviction and fill

   typedef logic [$clog2(WORDS_PER_LINE)-1:0] word_sel_t;

   typedef struct packed {
      logic [TAG_W-1:0]   tag;
      logic [INDEX_W-1:0] index;
      word_sel_t          word;
      logic               byte_sel;  // must stay clear, word accesses only
   } addr_t;

   typedef enum logic [2:0] {
      IDLE,
      COMPARE,
      CHECK,
      EVICT,
      EVICT_WAIT,
      LOAD,
      FINISH
   } ctrl_state_t;

   typedef enum logic [1:0] {
      MEM_NONE,
      MEM_READ,
      MEM_WRITE
   } mem_op_t;

   typedef struct packed {
      mem_op_t            op;
      logic [ADDR_W-1:0]  addr;
      logic [DATA_W-1:0]  wdata;
   } mem_req_t;

   typedef struct packed {
      logic               enable;
      logic               comp;      // tag compare access
      logic               write;
      logic               valid_in;
      logic [TAG_W-1:0]   tag;
      logic [INDEX_W-1:0] index;
      word_sel_t          word;
      logic [DATA_W-1:0]  wdata;
   } way_cmd_t;

   typedef struct packed {
      logic               hit;
      logic               valid;
      logic               dirty;
      logic [TAG_W-1:0]   tag;
      logic [DATA_W-1:0]  rdata;
   } way_status_t;

endpackage

`default_nettype wire
